// File: list.f
src/fixed_point_pkg.sv
src/fixed_point_op_if.sv
src/fixed_point_divide.sv
src/fixed_point_multiply.sv
src/fixed_point_op_ctrl.sv
src/fixed_point_unit.sv
dv/fixed_point_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= fixed_point_unit_tb
RTL_TOP ?= fixed_point_unit
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/fixed_point_unit_tb.sv
// Self-checking testbench for the fixed-point unit, vector table followed by random operations
`timescale 1ns/100ps
`default_nettype none

module fixed_point_unit_tb;

    localparam int w = fixed_point_pkg::width;
    localparam int num_vectors = 29;
    localparam int num_random = 40;
    localparam int num_ops = num_vectors + num_random + 2;     // Busy test adds two requests
    localparam int cycle_limit = num_ops * 40 + 100;
    localparam longint mag_limit = (longint'(1) <<< fixed_point_pkg::mag_width) - 1;

    typedef struct {
        fixed_point_pkg::fx_opcode_e op;
        logic signed [w-1:0] a;
        logic signed [w-1:0] b;
        logic signed [w-1:0] res;
        logic dbz;
        logic ovf;
    } vector_t;

    logic clk;
    logic rstn;
    logic start;
    fixed_point_pkg::fx_opcode_e op;
    logic signed [w-1:0] a;
    logic signed [w-1:0] b;
    logic busy;
    logic done;
    logic valid;
    logic dbz;
    logic ovf;
    logic signed [w-1:0] result;

    vector_t vectors [num_vectors];
    logic [63:0] rng_state;
    int cycle_count = 0;

    fixed_point_unit dut_i (
        .clk    (clk),
        .rstn   (rstn),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .done   (done),
        .valid  (valid),
        .dbz    (dbz),
        .ovf    (ovf),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Ends a run that stops answering
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the unit never finished its requests",
                     cycle_count);
            $display("Test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [63:0] xorshift64(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    // Arithmetic shift spreads operands over small and large magnitudes
    function automatic logic signed [w-1:0] shape_operand(input logic [63:0] r);
        logic signed [w-1:0] raw;
        raw = r[w-1:0];
        return raw >>> r[w+2:w];
    endfunction

    // Expected response from the Q5.12 rules, computed on wide integers
    task automatic model_op(
        input fixed_point_pkg::fx_opcode_e op_in,
        input logic signed [w-1:0] a_in,
        input logic signed [w-1:0] b_in,
        input logic signed [w-1:0] prev,
        output logic signed [w-1:0] exp_res,
        output logic exp_dbz,
        output logic exp_ovf
    );
        longint sa;
        longint sb;
        longint num;
        longint den;
        longint quot;
        longint rem;
        longint signed_quot;
        logic neg;
        sa = longint'(a_in);
        sb = longint'(b_in);
        exp_res = prev;                         // Errors keep the old result
        exp_dbz = 1'b0;
        exp_ovf = 1'b0;
        if (op_in == fixed_point_pkg::op_div) begin
            if (b_in == '0) begin
                exp_dbz = 1'b1;
            end else if (a_in == fixed_point_pkg::smallest || b_in == fixed_point_pkg::smallest) begin
                exp_ovf = 1'b1;
            end else begin
                neg = (sa < 0) != (sb < 0);
                num = (sa < 0 ? -sa : sa) <<< fixed_point_pkg::frac_bits;
                den = sb < 0 ? -sb : sb;
                quot = num / den;
                rem = num % den;
                if ((2 * rem > den) || ((2 * rem == den) && quot[0])) begin
                    quot = quot + 1;            // Half to even
                end
                if (quot > mag_limit) begin
                    exp_ovf = 1'b1;
                end else begin
                    signed_quot = neg ? -quot : quot;
                    exp_res = signed_quot[w-1:0];
                end
            end
        end else begin
            num = sa * sb;
            quot = num >>> fixed_point_pkg::frac_bits;  // Floor of the scaled product
            rem = num - (quot <<< fixed_point_pkg::frac_bits);
            if ((rem > 2048) || ((rem == 2048) && quot[0])) begin
                quot = quot + 1;
            end
            if (a_in == fixed_point_pkg::smallest || b_in == fixed_point_pkg::smallest
                || quot > mag_limit || quot < -mag_limit - 1) begin
                exp_ovf = 1'b1;
            end else begin
                exp_res = quot[w-1:0];
            end
        end
    endtask

    task automatic check_result(input string name, input logic signed [w-1:0] got,
                                input logic signed [w-1:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%05h, expected 0x%05h", name, got, exp);
            $display("Test failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_busy(input logic exp);
        if (busy !== exp) begin
            $display("error busy: got 0x%0h, expected 0x%0h", busy, exp);
            $display("Test failed");
            $fatal(1, "wrong value on busy");
        end
    endtask

    // Drive and sample 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_done();
        while (done !== 1'b1) begin
            step();
        end
    endtask

    task automatic apply_and_check(
        input fixed_point_pkg::fx_opcode_e op_in,
        input logic signed [w-1:0] a_in,
        input logic signed [w-1:0] b_in,
        input logic signed [w-1:0] exp_res,
        input logic exp_dbz,
        input logic exp_ovf
    );
        op = op_in;
        a = a_in;
        b = b_in;
        start = 1'b1;
        step();
        start = 1'b0;
        wait_done();
        check_result("result", result, exp_res);
        check_flag("dbz", dbz, exp_dbz);
        check_flag("ovf", ovf, exp_ovf);
        check_flag("valid", valid, !(exp_dbz || exp_ovf));
        check_busy(1'b0);
    endtask

    task automatic set_vector(input int idx, input fixed_point_pkg::fx_opcode_e op_in,
                              input logic [w-1:0] a_in, input logic [w-1:0] b_in,
                              input logic [w-1:0] res, input logic dbz_in, input logic ovf_in);
        vectors[idx] = '{op_in, a_in, b_in, res, dbz_in, ovf_in};
    endtask

    // Hex codes are Q5.12, error rows repeat the last good result
    task automatic fill_vectors();
        set_vector(0,  fixed_point_pkg::op_div, 18'h06000, 18'h02000, 18'h03000, 0, 0);
        set_vector(1,  fixed_point_pkg::op_div, 18'h3A000, 18'h02000, 18'h3D000, 0, 0);
        set_vector(2,  fixed_point_pkg::op_div, 18'h06000, 18'h3E000, 18'h3D000, 0, 0);
        set_vector(3,  fixed_point_pkg::op_div, 18'h3A000, 18'h3E000, 18'h03000, 0, 0);
        set_vector(4,  fixed_point_pkg::op_div, 18'h01000, 18'h03000, 18'h00555, 0, 0);
        set_vector(5,  fixed_point_pkg::op_div, 18'h3E000, 18'h03000, 18'h3F555, 0, 0);
        set_vector(6,  fixed_point_pkg::op_div, 18'h1F000, 18'h00800, 18'h3F555, 0, 1);
        set_vector(7,  fixed_point_pkg::op_div, 18'h00003, 18'h02000, 18'h00002, 0, 0);
        set_vector(8,  fixed_point_pkg::op_div, 18'h02000, 18'h00000, 18'h00002, 1, 0);
        set_vector(9,  fixed_point_pkg::op_div, 18'h3FFFB, 18'h02000, 18'h3FFFE, 0, 0);
        set_vector(10, fixed_point_pkg::op_div, 18'h20000, 18'h01000, 18'h3FFFE, 0, 1);
        set_vector(11, fixed_point_pkg::op_div, 18'h00001, 18'h02000, 18'h00000, 0, 0);
        set_vector(12, fixed_point_pkg::op_div, 18'h3FFFF, 18'h02000, 18'h00000, 0, 0);
        set_vector(13, fixed_point_pkg::op_div, 18'h20000, 18'h00000, 18'h00000, 1, 0);
        set_vector(14, fixed_point_pkg::op_div, 18'h1F000, 18'h01000, 18'h1F000, 0, 0);
        set_vector(15, fixed_point_pkg::op_mul, 18'h01800, 18'h02000, 18'h03000, 0, 0);
        set_vector(16, fixed_point_pkg::op_mul, 18'h3E800, 18'h02000, 18'h3D000, 0, 0);
        set_vector(17, fixed_point_pkg::op_mul, 18'h3E800, 18'h3E000, 18'h03000, 0, 0);
        set_vector(18, fixed_point_pkg::op_mul, 18'h01800, 18'h3E000, 18'h3D000, 0, 0);
        set_vector(19, fixed_point_pkg::op_mul, 18'h00001, 18'h00800, 18'h00000, 0, 0);
        set_vector(20, fixed_point_pkg::op_mul, 18'h00003, 18'h00800, 18'h00002, 0, 0);
        set_vector(21, fixed_point_pkg::op_mul, 18'h3FFFD, 18'h00800, 18'h3FFFE, 0, 0);
        set_vector(22, fixed_point_pkg::op_mul, 18'h3FFFF, 18'h00800, 18'h00000, 0, 0);
        set_vector(23, fixed_point_pkg::op_mul, 18'h00003, 18'h00C00, 18'h00002, 0, 0);
        set_vector(24, fixed_point_pkg::op_mul, 18'h30000, 18'h02000, 18'h20000, 0, 0);
        set_vector(25, fixed_point_pkg::op_mul, 18'h10000, 18'h02000, 18'h20000, 0, 1);
        set_vector(26, fixed_point_pkg::op_mul, 18'h01000, 18'h01000, 18'h01000, 0, 0);
        set_vector(27, fixed_point_pkg::op_mul, 18'h20000, 18'h00000, 18'h01000, 0, 1);
        set_vector(28, fixed_point_pkg::op_mul, 18'h3F000, 18'h3F000, 18'h01000, 0, 0);
    endtask

    initial begin
        fixed_point_pkg::fx_opcode_e rop;
        logic signed [w-1:0] ra;
        logic signed [w-1:0] rb;
        logic signed [w-1:0] exp_res;
        logic signed [w-1:0] last_good;
        logic exp_dbz;
        logic exp_ovf;

        rstn = 1'b0;
        start = 1'b0;
        op = fixed_point_pkg::op_div;
        a = '0;
        b = '0;
        rng_state = 64'd36;
        last_good = '0;
        fill_vectors();

        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        step();
        check_busy(1'b0);
        check_flag("done", done, 1'b0);
        check_flag("valid", valid, 1'b0);
        check_flag("dbz", dbz, 1'b0);
        check_flag("ovf", ovf, 1'b0);
        check_result("result", result, '0);

        for (int i = 0; i < num_vectors; i++) begin
            apply_and_check(vectors[i].op, vectors[i].a, vectors[i].b,
                            vectors[i].res, vectors[i].dbz, vectors[i].ovf);
            last_good = vectors[i].res;
        end

        for (int n = 0; n < num_random; n++) begin
            rng_state = xorshift64(rng_state);
            rop = rng_state[40] ? fixed_point_pkg::op_mul : fixed_point_pkg::op_div;
            ra = shape_operand(rng_state);
            rng_state = xorshift64(rng_state);
            rb = shape_operand(rng_state);
            model_op(rop, ra, rb, last_good, exp_res, exp_dbz, exp_ovf);
            apply_and_check(rop, ra, rb, exp_res, exp_dbz, exp_ovf);
            last_good = exp_res;
        end

        // Second request during a divide must be dropped
        model_op(fixed_point_pkg::op_div, 18'h06000, 18'h02000, last_good,
                 exp_res, exp_dbz, exp_ovf);
        op = fixed_point_pkg::op_div;
        a = 18'h06000;
        b = 18'h02000;
        start = 1'b1;
        step();
        start = 1'b0;
        check_busy(1'b1);
        step();
        check_busy(1'b1);
        op = fixed_point_pkg::op_mul;
        a = 18'h01000;
        b = 18'h01000;
        start = 1'b1;
        step();
        start = 1'b0;
        wait_done();
        check_result("result", result, exp_res);
        check_flag("dbz", dbz, exp_dbz);
        check_flag("ovf", ovf, exp_ovf);
        check_flag("valid", valid, 1'b1);
        repeat (5) begin
            step();
            check_flag("done", done, 1'b0);
            check_busy(1'b0);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/fixed_point_unit.sv
// Fixed-point unit top level joining the control block to the divide and multiply engines
`timescale 1ns/100ps
`default_nettype none

module fixed_point_unit (
    input wire clk,
    input wire rstn,
    input wire start,
    input wire fixed_point_pkg::fx_opcode_e op,
    input wire logic signed [fixed_point_pkg::width-1:0] a,
    input wire logic signed [fixed_point_pkg::width-1:0] b,
    output logic busy,
    output logic done,
    output logic valid,
    output logic dbz,
    output logic ovf,
    output logic signed [fixed_point_pkg::width-1:0] result
);

    fixed_point_op_if div_if ();
    fixed_point_op_if mul_if ();

    fixed_point_op_ctrl ctrl_i (
        .clk    (clk),
        .rstn   (rstn),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .done   (done),
        .valid  (valid),
        .dbz    (dbz),
        .ovf    (ovf),
        .result (result),
        .div    (div_if),
        .mul    (mul_if)
    );

    fixed_point_divide div_i (
        .clk  (clk),
        .rstn (rstn),
        .op   (div_if)
    );

    fixed_point_multiply mul_i (
        .clk  (clk),
        .rstn (rstn),
        .op   (mul_if)
    );

endmodule

`default_nettype wire

// File: src/fixed_point_op_ctrl.sv
// Dispatches one request at a time to the divider or multiplier and holds the result
`timescale 1ns/100ps
`default_nettype none

module fixed_point_op_ctrl (
    input wire clk,
    input wire rstn,
    input wire start,
    input wire fixed_point_pkg::fx_opcode_e op,
    input wire logic signed [fixed_point_pkg::width-1:0] a,
    input wire logic signed [fixed_point_pkg::width-1:0] b,
    output logic busy,
    output logic done,
    output logic valid,
    output logic dbz,
    output logic ovf,
    output logic signed [fixed_point_pkg::width-1:0] result,
    fixed_point_op_if.ctrl div,
    fixed_point_op_if.ctrl mul
);

    fixed_point_pkg::ctrl_state_e state;

    logic signed [fixed_point_pkg::width-1:0] a_q;
    logic signed [fixed_point_pkg::width-1:0] b_q;
    logic div_start;
    logic mul_start;
    logic eng_done;
    logic eng_valid;
    logic eng_dbz;
    logic eng_ovf;
    logic signed [fixed_point_pkg::width-1:0] eng_q;

    assign div.start = div_start;
    assign div.a = a_q;
    assign div.b = b_q;
    assign mul.start = mul_start;
    assign mul.a = a_q;
    assign mul.b = b_q;

    assign busy = (state != fixed_point_pkg::ctrl_idle);

    // Response from whichever engine holds the request
    always_comb begin
        eng_done = ((state == fixed_point_pkg::wait_div) && div.done)
                || ((state == fixed_point_pkg::wait_mul) && mul.done);
        eng_valid = (state == fixed_point_pkg::wait_mul) ? mul.valid : div.valid;
        eng_dbz = (state == fixed_point_pkg::wait_mul) ? mul.dbz : div.dbz;
        eng_ovf = (state == fixed_point_pkg::wait_mul) ? mul.ovf : div.ovf;
        eng_q = (state == fixed_point_pkg::wait_mul) ? mul.q : div.q;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= fixed_point_pkg::ctrl_idle;
            div_start <= 1'b0;
            mul_start <= 1'b0;
            done <= 1'b0;
            valid <= 1'b0;
            dbz <= 1'b0;
            ovf <= 1'b0;
            result <= '0;
        end else begin
            div_start <= 1'b0;
            mul_start <= 1'b0;
            done <= 1'b0;
            case (state)
                fixed_point_pkg::ctrl_idle: begin
                    if (start) begin
                        if (op == fixed_point_pkg::op_mul) begin
                            mul_start <= 1'b1;
                            state <= fixed_point_pkg::wait_mul;
                        end else begin
                            div_start <= 1'b1;
                            state <= fixed_point_pkg::wait_div;
                        end
                    end
                end
                fixed_point_pkg::wait_div, fixed_point_pkg::wait_mul: begin
                    if (eng_done) begin
                        state <= fixed_point_pkg::ctrl_idle;
                        done <= 1'b1;
                        valid <= eng_valid;
                        dbz <= eng_dbz;
                        ovf <= eng_ovf;
                        if (eng_valid) begin
                            result <= eng_q;    // Errors keep the last good result
                        end
                    end
                end
                default: state <= fixed_point_pkg::ctrl_idle;
            endcase
        end
    end

    // Operands held for the engine until its done
    always_ff @(posedge clk) begin
        if ((state == fixed_point_pkg::ctrl_idle) && start) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // Engine start only follows an accepted request in idle
    assert property (@(posedge clk) disable iff (!rstn)
        (div.start || mul.start) |-> ($past(state) == fixed_point_pkg::ctrl_idle) && $past(start));

endmodule

`default_nettype wire

// File: src/fixed_point_multiply.sv
// Signed Q5.12 multiplier with half-to-even rounding, result one cycle after start
`timescale 1ns/100ps
`default_nettype none

module fixed_point_multiply (
    input wire clk,
    input wire rstn,
    fixed_point_op_if.engine op
);

    logic signed [fixed_point_pkg::prod_width-1:0] product;
    logic [fixed_point_pkg::rnd_width-1:0] rounded;
    logic round_up;
    logic fits;
    logic min_in;
    logic ovf_c;

    always_comb begin
        product = op.a * op.b;
        // Half of the dropped range, ties go to the even neighbour
        round_up = product[fixed_point_pkg::frac_bits-1]
                && ((product[fixed_point_pkg::frac_bits-2:0] != '0)
                    || product[fixed_point_pkg::frac_bits]);
        rounded = {product[fixed_point_pkg::prod_width-1],
                   product[fixed_point_pkg::prod_width-1:fixed_point_pkg::frac_bits]}
                + {{(fixed_point_pkg::rnd_width-1){1'b0}}, round_up};
        // Upper bits must all repeat the result sign
        fits = (rounded[fixed_point_pkg::rnd_width-1:fixed_point_pkg::width-1] == '0)
            || (rounded[fixed_point_pkg::rnd_width-1:fixed_point_pkg::width-1] == '1);
        min_in = (op.a == fixed_point_pkg::smallest) || (op.b == fixed_point_pkg::smallest);
        ovf_c = min_in || !fits;
    end

    assign op.busy = op.start;      // Work happens in the start cycle
    assign op.dbz = 1'b0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            op.done <= 1'b0;
            op.valid <= 1'b0;
            op.ovf <= 1'b0;
        end else begin
            op.done <= op.start;
            if (op.start) begin
                op.ovf <= ovf_c;
                op.valid <= !ovf_c;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.start) begin
            op.q <= rounded[fixed_point_pkg::width-1:0];
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) op.done == $past(op.start));

endmodule

`default_nettype wire

// File: src/fixed_point_divide.sv
// Iterative signed Q5.12 divider, restoring division with half-to-even rounding
`timescale 1ns/100ps
`default_nettype none

module fixed_point_divide (
    input wire clk,
    input wire rstn,
    fixed_point_op_if.engine op
);

    fixed_point_pkg::divide_state_e state;

    logic [fixed_point_pkg::mag_width-1:0] a_mag;
    logic [fixed_point_pkg::mag_width-1:0] b_mag;
    logic sign_diff;
    logic [fixed_point_pkg::mag_width-1:0] quo;
    logic [fixed_point_pkg::mag_width-1:0] quo_next;
    logic [fixed_point_pkg::mag_width:0] acc;
    logic [fixed_point_pkg::mag_width:0] acc_next;
    logic [fixed_point_pkg::mag_width:0] rem;
    logic [fixed_point_pkg::mag_width:0] quo_inc;
    fixed_point_pkg::iter_t i;

    logic ge;
    logic dbz_in;
    logic min_in;
    logic int_ovf;
    logic last_iter;
    logic round_up;

    assign dbz_in = (op.b == '0);
    assign min_in = (op.a == fixed_point_pkg::smallest) || (op.b == fixed_point_pkg::smallest);

    // One restoring step, next dividend bit comes from the top of quo
    always_comb begin
        ge = (acc >= {1'b0, b_mag});
        rem = ge ? (acc - {1'b0, b_mag}) : acc;
        acc_next = {rem[fixed_point_pkg::mag_width-1:0], quo[fixed_point_pkg::mag_width-1]};
        quo_next = {quo[fixed_point_pkg::mag_width-2:0], ge};
    end

    // First bits out of the divider are the high integer bits
    assign int_ovf = (i == fixed_point_pkg::iter_t'(fixed_point_pkg::mag_width - 1))
                  && (quo_next[fixed_point_pkg::mag_width-1 -: fixed_point_pkg::frac_bits] != '0);
    assign last_iter = (i == fixed_point_pkg::iter_t'(fixed_point_pkg::iterations - 1));

    // Next bit set, then odd quotient or leftover remainder breaks the tie
    assign round_up = quo_next[0] && (quo[0] || (acc_next[fixed_point_pkg::mag_width:1] != '0));
    assign quo_inc = {1'b0, quo} + {{fixed_point_pkg::mag_width{1'b0}}, 1'b1};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= fixed_point_pkg::div_idle;
            op.busy <= 1'b0;
            op.done <= 1'b0;
            op.valid <= 1'b0;
            op.dbz <= 1'b0;
            op.ovf <= 1'b0;
        end else begin
            op.done <= 1'b0;
            case (state)
                fixed_point_pkg::div_idle: begin
                    if (op.start) begin
                        op.valid <= 1'b0;
                        op.dbz <= dbz_in;
                        op.ovf <= !dbz_in && min_in;
                        if (dbz_in || min_in) begin
                            op.done <= 1'b1;        // Rejected, busy stays low
                        end else begin
                            state <= fixed_point_pkg::div_init;
                            op.busy <= 1'b1;
                        end
                    end
                end
                fixed_point_pkg::div_init: state <= fixed_point_pkg::div_calc;
                fixed_point_pkg::div_calc: begin
                    if (int_ovf) begin
                        state <= fixed_point_pkg::div_idle;
                        op.busy <= 1'b0;
                        op.done <= 1'b1;
                        op.ovf <= 1'b1;
                    end else if (last_iter) begin
                        state <= fixed_point_pkg::div_round;
                    end
                end
                fixed_point_pkg::div_round: begin
                    if (round_up && quo_inc[fixed_point_pkg::mag_width]) begin
                        // Rounding carried past the magnitude
                        state <= fixed_point_pkg::div_idle;
                        op.busy <= 1'b0;
                        op.done <= 1'b1;
                        op.ovf <= 1'b1;
                    end else begin
                        state <= fixed_point_pkg::div_sign;
                    end
                end
                fixed_point_pkg::div_sign: begin
                    state <= fixed_point_pkg::div_idle;
                    op.busy <= 1'b0;
                    op.done <= 1'b1;
                    op.valid <= 1'b1;
                end
                default: state <= fixed_point_pkg::div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            fixed_point_pkg::div_idle: begin
                a_mag <= op.a[fixed_point_pkg::width-1] ? -op.a[fixed_point_pkg::mag_width-1:0]
                                                        : op.a[fixed_point_pkg::mag_width-1:0];
                b_mag <= op.b[fixed_point_pkg::width-1] ? -op.b[fixed_point_pkg::mag_width-1:0]
                                                        : op.b[fixed_point_pkg::mag_width-1:0];
                sign_diff <= op.a[fixed_point_pkg::width-1] ^ op.b[fixed_point_pkg::width-1];
            end
            fixed_point_pkg::div_init: begin
                i <= '0;
                {acc, quo} <= {{fixed_point_pkg::mag_width{1'b0}}, a_mag, 1'b0};  // Pre-shifted
            end
            fixed_point_pkg::div_calc: begin
                i <= i + 1'b1;
                acc <= acc_next;
                quo <= quo_next;
            end
            fixed_point_pkg::div_round: begin
                if (round_up) begin
                    quo <= quo_inc[fixed_point_pkg::mag_width-1:0];
                end
            end
            fixed_point_pkg::div_sign: begin
                if (quo == '0) begin
                    op.q <= '0;                     // No negative zero
                end else begin
                    op.q <= sign_diff ? {1'b1, -quo} : {1'b0, quo};
                end
            end
            default: ;
        endcase
    end

    // Control block must wait for the previous division
    assert property (@(posedge clk) disable iff (!rstn) op.start |-> !op.busy);

    assert property (@(posedge clk) disable iff (!rstn) !(op.done && op.busy));

endmodule

`default_nettype wire

// File: src/fixed_point_op_if.sv
// Request and response bundle between the control block and one arithmetic engine
`timescale 1ns/100ps
`default_nettype none

interface fixed_point_op_if;

    logic start;                                    // One-cycle request pulse
    logic signed [fixed_point_pkg::width-1:0] a;    // Held until done
    logic signed [fixed_point_pkg::width-1:0] b;

    logic busy;
    logic done;                                     // One pulse per start
    logic valid;                                    // Last result is good
    logic dbz;
    logic ovf;
    logic signed [fixed_point_pkg::width-1:0] q;    // Quotient or product

    modport ctrl (
        output start,
        output a,
        output b,
        input  busy,
        input  done,
        input  valid,
        input  dbz,
        input  ovf,
        input  q
    );

    modport engine (
        input  start,
        input  a,
        input  b,
        output busy,
        output done,
        output valid,
        output dbz,
        output ovf,
        output q
    );

endinterface

`default_nettype wire

// File: src/fixed_point_pkg.sv
// Fixed-point unit package with Q5.12 widths, special codes and FSM encodings
`default_nettype none

package fixed_point_pkg;

    localparam int width = 18;                          // Sign, 5 integer and 12 fraction bits
    localparam int frac_bits = 12;
    localparam int mag_width = width - 1;               // Magnitude without the sign
    localparam int iterations = mag_width + frac_bits;  // One quotient bit per cycle
    localparam int cnt_width = $clog2(iterations + 1);
    localparam int prod_width = 2 * width;              // Full signed product
    localparam int rnd_width = prod_width - frac_bits + 1;

    // Most negative code, has no positive counterpart
    localparam logic [width-1:0] smallest = {1'b1, {mag_width{1'b0}}};

    typedef logic [cnt_width-1:0] iter_t;

    typedef enum logic {
        op_div,
        op_mul
    } fx_opcode_e;

    typedef enum logic [2:0] {
        div_idle,
        div_init,
        div_calc,
        div_round,
        div_sign
    } divide_state_e;

    typedef enum logic [1:0] {
        ctrl_idle,
        wait_div,
        wait_mul
    } ctrl_state_e;

endpackage

`default_nettype wire
